// File: all.f
logic/frame_pkg.sv
logic/stream_buffer.sv
logic/beat_counter.sv
logic/header_field_capture.sv
logic/header_decode.sv
logic/frame_parser_top.sv
sim/frame_parser_checker.sv
sim/frame_parser_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the frame parser testbench with Verilator, run it and
# judge the run by the pass line in the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module frame_parser_tb -f all.f -o frame_parser_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/frame_parser_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: sim/frame_parser_tb.sv
/*
 * Testbench for the frame header parser. Frames from a table are
 * sent byte by byte with random gaps and random output stalls, and
 * the output bytes, header info and frame status are compared with
 * a reference model built from the same table.
 */
`timescale 1ns/1ns

module frame_parser_tb
    import frame_pkg::*;
;

    localparam int HDR_BYTES = 4;

    typedef struct packed {
        logic [7:0]  frame_type;
        logic [7:0]  seq_num;
        logic [15:0] payload_len;
        logic [15:0] byte_count;
    } row_t;

    logic          clock;
    logic          rst_n;
    logic          in_valid;
    stream_beat_t  in_beat;
    logic          in_ready;
    logic          out_valid;
    stream_beat_t  out_beat;
    logic          out_ready;
    header_info_t  info;
    logic          info_valid;
    frame_status_t status;
    logic          status_valid;

    row_t          rows [$];
    stream_beat_t  in_beats [$];
    stream_beat_t  exp_beats [$];
    header_info_t  exp_infos [$];
    frame_status_t exp_stats [$];
    logic [31:0]   lcg_state = 32'hc724f858;
    int            error_count = 0;
    int            check_count = 0;
    int            cycle_count = 0;
    int            cycle_limit = 0;

    frame_parser_top #(
        .HDR_BYTES (HDR_BYTES)
    ) u_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_beat     (out_beat),
        .out_ready    (out_ready),
        .info         (info),
        .info_valid   (info_valid),
        .status       (status),
        .status_valid (status_valid)
    );

    bind frame_parser_top frame_parser_checker u_checker (
        .clock        (clock),
        .rst_n        (rst_n),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_beat     (out_beat),
        .info_valid   (info_valid),
        .status_valid (status_valid)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input logic [7:0] ftype, input logic [7:0] seq,
                           input logic [15:0] len, input logic [15:0] count);
        rows.push_back({ftype, seq, len, count});
    endtask

    // reference model, one row becomes bytes, an info and a status.
    task automatic expand_rows();
        row_t          row;
        stream_beat_t  beat;
        frame_status_t st;
        logic [31:0]   r;
        foreach (rows[i]) begin
            row = rows[i];
            for (int b = 0; b < int'(row.byte_count); b++) begin
                case (b)
                    0:       beat.data = row.frame_type;
                    1:       beat.data = row.seq_num;
                    2:       beat.data = row.payload_len[15:8];
                    3:       beat.data = row.payload_len[7:0];
                    default: begin
                        r = next_rand();
                        beat.data = r[23:16];
                    end
                endcase
                beat.last = (b == int'(row.byte_count) - 1);
                in_beats.push_back(beat);
            end
            if (int'(row.byte_count) >= HDR_BYTES) begin
                exp_infos.push_back({row.frame_type, row.seq_num, row.payload_len});
            end
            st.short_frame = (int'(row.byte_count) < HDR_BYTES);
            st.len_ok      = !st.short_frame &&
                             (int'(row.byte_count) == int'(row.payload_len) + HDR_BYTES);
            st.beat_count  = row.byte_count;
            exp_stats.push_back(st);
        end
        exp_beats = in_beats;
    endtask

    // pulses are high for one full cycle, so each is seen at one falling edge.
    task automatic watch_pulses();
        if (info_valid) begin
            if (exp_infos.size() == 0) begin
                error_count++;
                $display("info_valid at %0t ns with no header expected", $time);
            end else begin
                compare_value("header info", 32'(info), 32'(exp_infos.pop_front()));
            end
        end
        if (status_valid) begin
            if (exp_stats.size() == 0) begin
                error_count++;
                $display("status_valid at %0t ns with no frame expected", $time);
            end else begin
                compare_value("frame status", 32'(status), 32'(exp_stats.pop_front()));
            end
        end
    endtask

    task automatic take_output_beat();
        if (exp_beats.size() == 0) begin
            error_count++;
            $display("extra output beat at %0t ns", $time);
        end else begin
            compare_value("output beat", 32'(out_beat), 32'(exp_beats.pop_front()));
        end
    endtask

    // ==================================================
    // watchdog
    // ==================================================
    initial begin
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, traffic did not drain", cycle_count);
        $display("Checks failed");
        $finish;
    end

    // ==================================================
    // stimulus and checking
    // ==================================================
    initial begin
        int          pos;
        logic        in_sent;
        logic [31:0] r;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b0;
        pos       = 0;
        in_sent   = 1'b0;

        add_row(8'h11, 8'h01, 16'd3,  16'd7);
        add_row(8'h22, 8'h02, 16'd0,  16'd4);
        add_row(8'h33, 8'h03, 16'd5,  16'd7);
        add_row(8'h44, 8'h04, 16'd2,  16'd9);
        add_row(8'h55, 8'h05, 16'd8,  16'd2);
        add_row(8'h66, 8'h06, 16'd6,  16'd10);
        add_row(8'h77, 8'h07, 16'd0,  16'd1);
        add_row(8'h88, 8'h08, 16'd4,  16'd3);
        add_row(8'h99, 8'h09, 16'd16, 16'd20);
        add_row(8'haa, 8'h0a, 16'd1,  16'd5);
        expand_rows();
        cycle_limit = in_beats.size() * 4 + 200;

        repeat (10) @(negedge clock);
        rst_n = 1'b1;

        // idle after reset.
        repeat (4) begin
            @(negedge clock);
            compare_value("in_ready idle", 32'(in_ready), 32'd1);
            compare_value("out_valid idle", 32'(out_valid), 32'd0);
            compare_value("info_valid idle", 32'(info_valid), 32'd0);
            compare_value("status_valid idle", 32'(status_valid), 32'd0);
        end

        while (pos < in_beats.size() || exp_beats.size() != 0 ||
               exp_infos.size() != 0 || exp_stats.size() != 0) begin
            @(negedge clock);
            watch_pulses();
            if (in_sent) begin
                pos++;
            end
            // a raised valid holds its beat until it is taken.
            if (!in_valid || in_sent) begin
                if (pos < in_beats.size()) begin
                    r        = next_rand();
                    in_valid = (r[31:30] != 2'b00);
                    in_beat  = in_beats[pos];
                end else begin
                    in_valid = 1'b0;
                end
            end
            r         = next_rand();
            out_ready = (r[31:30] != 2'b00);
            in_sent   = in_valid && in_ready;
            if (out_valid && out_ready) begin
                take_output_beat();
            end
        end

        // no stray pulses once traffic has drained.
        repeat (10) begin
            @(negedge clock);
            watch_pulses();
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim/frame_parser_checker.sv
/*
 * Concurrent assertions on the parser's output stream and status
 * pulses. Bound into frame_parser_top from the testbench.
 */
`timescale 1ns/1ns

module frame_parser_checker
    import frame_pkg::*;
(
    input logic         clock,
    input logic         rst_n,
    input logic         out_valid,
    input logic         out_ready,
    input stream_beat_t out_beat,
    input logic         info_valid,
    input logic         status_valid
);

    // a stalled beat stays offered and unchanged.
    a_out_hold: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat dropped or changed while stalled");

    a_info_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        info_valid |=> !info_valid)
        else $error("info_valid held longer than one cycle");

    // one status cycle per finished frame.
    a_status_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        status_valid |=> !status_valid)
        else $error("status_valid held longer than one cycle");

    a_reset_quiet: assert property (@(posedge clock)
        !rst_n |-> !out_valid && !info_valid)
        else $error("output or info valid during reset");

endmodule

// File: logic/frame_parser_top.sv
/*
 * Frame header parser top level.
 * Bytes pass unchanged through a two-entry buffer; the accepted
 * output beats feed the counter, header capture and decoder.
 * HDR_BYTES must be at least 4 to hold the decoded fields.
 */
`timescale 1ns/1ns

module frame_parser_top
    import frame_pkg::*;
#(
    parameter int HDR_BYTES = 4
) (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          in_valid,
    input  stream_beat_t  in_beat,
    output logic          in_ready,
    output logic          out_valid,
    output stream_beat_t  out_beat,
    input  logic          out_ready,
    output header_info_t  info,
    output logic          info_valid,
    output frame_status_t status,
    output logic          status_valid
);

    logic             out_fire;
    logic [CNT_W-1:0] beat_idx;
    logic [HDR_W-1:0] hdr_word;
    logic             hdr_pulse;
    logic             frame_end;
    logic             frame_short;

    // ==================================================
    // data path
    // ==================================================
    stream_buffer u_buffer (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // single tap on the output handshake.
    assign out_fire = out_valid && out_ready;

    // ==================================================
    // parser
    // ==================================================
    beat_counter u_counter (
        .clock    (clock),
        .rst_n    (rst_n),
        .fire     (out_fire),
        .last     (out_beat.last),
        .beat_idx (beat_idx)
    );

    header_field_capture #(
        .HDR_BYTES (HDR_BYTES)
    ) u_capture (
        .clock       (clock),
        .rst_n       (rst_n),
        .fire        (out_fire),
        .beat        (out_beat),
        .beat_idx    (beat_idx),
        .hdr_word    (hdr_word),
        .hdr_pulse   (hdr_pulse),
        .frame_end   (frame_end),
        .frame_short (frame_short)
    );

    header_decode #(
        .HDR_BYTES (HDR_BYTES)
    ) u_decode (
        .clock        (clock),
        .rst_n        (rst_n),
        .hdr_word     (hdr_word),
        .hdr_pulse    (hdr_pulse),
        .frame_end    (frame_end),
        .frame_short  (frame_short),
        .beat_idx     (beat_idx),
        .info         (info),
        .info_valid   (info_valid),
        .status       (status),
        .status_valid (status_valid)
    );

endmodule

// File: logic/header_decode.sv
/*
 * Splits the captured header word into type, sequence and length,
 * and at the end of each frame reports the byte count and whether
 * it matched the header plus the declared payload length.
 */
`timescale 1ns/1ns

module header_decode
    import frame_pkg::*;
#(
    parameter int HDR_BYTES = 4
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [HDR_W-1:0] hdr_word,
    input  logic             hdr_pulse,
    input  logic             frame_end,
    input  logic             frame_short,
    input  logic [CNT_W-1:0] beat_idx,
    output header_info_t     info,
    output logic             info_valid,
    output frame_status_t    status,
    output logic             status_valid
);

    header_info_t     word_info;
    logic [CNT_W-1:0] count_hold;
    logic [15:0]      len_src;
    logic [CNT_W:0]   frame_bytes;
    logic [CNT_W:0]   expect_bytes;

    // field layout of the first four header bytes.
    assign word_info.frame_type  = hdr_word[HDR_W-1 -: DATA_W];
    assign word_info.seq_num     = hdr_word[HDR_W-1-DATA_W -: DATA_W];
    assign word_info.payload_len = hdr_word[HDR_W-1-2*DATA_W -: 16];

    // a frame of exactly HDR_BYTES ends in the same cycle its header completes.
    assign len_src      = hdr_pulse ? word_info.payload_len : info.payload_len;
    assign frame_bytes  = {1'b0, count_hold} + 1'b1;
    assign expect_bytes = {1'b0, len_src} + (CNT_W+1)'(HDR_BYTES);

    // previous cycle's index, the last beat's position at frame_end.
    always_ff @(posedge clock) begin
        count_hold <= beat_idx;
        if (hdr_pulse) begin
            info <= word_info;
        end
        if (frame_end) begin
            status.short_frame <= frame_short;
            status.len_ok      <= !frame_short && (frame_bytes == expect_bytes);
            status.beat_count  <= frame_bytes[CNT_W-1:0];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            info_valid   <= 1'b0;
            status_valid <= 1'b0;
        end else begin
            info_valid   <= hdr_pulse;
            status_valid <= frame_end;
        end
    end

endmodule

// File: logic/header_field_capture.sv
/*
 * Watches the accepted output stream and stores the first HDR_BYTES
 * bytes of every frame into one wide header word, byte 0 on top.
 * Pulses hdr_pulse when the header is complete and frame_end after
 * the last beat, with frame_short marking frames cut before that.
 */
`timescale 1ns/1ns

module header_field_capture
    import frame_pkg::*;
#(
    parameter int HDR_BYTES = 4
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             fire,
    input  stream_beat_t     beat,
    input  logic [CNT_W-1:0] beat_idx,
    output logic [HDR_W-1:0] hdr_word,
    output logic             hdr_pulse,
    output logic             frame_end,
    output logic             frame_short
);

    localparam int IDX_W = $clog2(HDR_BYTES_MAX);

    logic [DATA_W-1:0] hdr_bytes [0:HDR_BYTES_MAX-1];
    logic              in_window;
    logic              hdr_done;
    logic              early_end;

    // window is open from the first beat until HDR_BYTES are taken.
    assign in_window = (beat_idx < CNT_W'(HDR_BYTES));
    assign hdr_done  = (beat_idx == CNT_W'(HDR_BYTES - 1));
    assign early_end = (beat_idx < CNT_W'(HDR_BYTES - 1));

    // ==================================================
    // header byte store
    // ==================================================
    always_ff @(posedge clock) begin
        if (fire && in_window) begin
            hdr_bytes[beat_idx[IDX_W-1:0]] <= beat.data;
        end
    end

    // present the array as one packed word.
    always_comb begin
        for (int i = 0; i < HDR_BYTES_MAX; i++) begin
            hdr_word[(HDR_BYTES_MAX-1-i)*DATA_W +: DATA_W] = hdr_bytes[i];
        end
    end

    // ==================================================
    // event pulses
    // ==================================================
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hdr_pulse   <= 1'b0;
            frame_end   <= 1'b0;
            frame_short <= 1'b0;
        end else begin
            hdr_pulse   <= fire && hdr_done;
            frame_end   <= fire && beat.last;
            // a frame that ends before the header is complete.
            frame_short <= fire && beat.last && early_end;
        end
    end

endmodule

// File: logic/beat_counter.sv
/*
 * Position of the current beat within its frame.
 * Steps on every accepted output beat and returns to zero
 * after the beat that carries last.
 */
`timescale 1ns/1ns

module beat_counter
    import frame_pkg::*;
(
    input  logic             clock,
    input  logic             rst_n,
    input  logic             fire,
    input  logic             last,
    output logic [CNT_W-1:0] beat_idx
);

    logic at_max;

    // holds at the top value on oversized frames.
    assign at_max = (beat_idx == {CNT_W{1'b1}});

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
        end else if (fire) begin
            if (last) begin
                beat_idx <= '0;
            end else if (!at_max) begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

endmodule

// File: logic/stream_buffer.sv
/*
 * Two-entry FIFO between the input and output byte streams.
 * Input ready drops only when both entries are full, so the
 * upstream keeps flowing for one extra beat while the output stalls.
 */
`timescale 1ns/1ns

module stream_buffer
    import frame_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  logic         in_valid,
    input  stream_beat_t in_beat,
    output logic         in_ready,
    output logic         out_valid,
    output stream_beat_t out_beat,
    input  logic         out_ready
);

    stream_beat_t mem [0:1];
    logic         wr_ptr;
    logic         rd_ptr;
    logic [1:0]   count;
    logic         push;
    logic         pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_beat  = mem[rd_ptr];

    // storage entries.
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // ==================================================
    // pointers and fill level
    // ==================================================
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/frame_pkg.sv
/*
 * Shared types and widths for the frame header parser.
 * Every design file imports this package for the stream beat,
 * the decoded header info and the per-frame status.
 */
package frame_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int DATA_W        = 8;
    localparam int HDR_BYTES_MAX = 16;
    localparam int HDR_W         = HDR_BYTES_MAX * DATA_W;
    localparam int CNT_W         = 16;

    // ==================================================
    // structs
    // ==================================================

    // one byte beat on a stream, valid and ready travel separately.
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } stream_beat_t;

    // fields taken from the first four header bytes.
    typedef struct packed {
        logic [7:0]  frame_type;
        logic [7:0]  seq_num;
        logic [15:0] payload_len;
    } header_info_t;

    // summary of one finished frame.
    typedef struct packed {
        logic             short_frame;
        logic             len_ok;
        logic [CNT_W-1:0] beat_count;
    } frame_status_t;

endpackage
